// File: verilog/motor3_cfg.svh
`ifndef MOTOR3_CFG_SVH
`define MOTOR3_CFG_SVH

// ######################################################################
// Step timing
`define M3_PERIOD_W     25
`define M3_STEPS        12
`define M3_OFS_B        8
`define M3_OFS_C        4

// ######################################################################
// Speed range, in clk cycles per step
`define M3_PERIOD_INIT  20
`define M3_PERIOD_MIN   4
`define M3_PERIOD_MAX   40
`define M3_PERIOD_STEP  4
`define M3_ROUND_W      16

`endif

// File: verilog/motorPkg.sv
`include "motor3_cfg.svh"

package motorPkg;

    // 0..11 valid and upper codes mark idle
    typedef logic [3:0] stepIdxT;

    typedef logic [`M3_PERIOD_W-1:0] periodT;  // Cycles per step

    typedef logic [`M3_ROUND_W-1:0] roundCntT;  // Electrical rounds since start

endpackage

// File: verilog/drivePkg.sv
package drivePkg;

    typedef enum logic [1:0] {
        bridgeOff,
        bridgeHigh,
        bridgeLow
    } bridgeStateT;

    typedef logic [1:0] gatePairT;  // [1] high switch, [0] low switch

endpackage

// File: verilog/stepIf.sv
interface stepIf;

    motorPkg::stepIdxT stepA;
    motorPkg::stepIdxT stepB;
    motorPkg::stepIdxT stepC;
    logic              stepAdv;  // High in the cycle the steps change
    logic              run;

    modport seq (
        output stepA, stepB, stepC, stepAdv, run
    );

    modport drv (
        input stepA, stepB, stepC, stepAdv, run
    );

endinterface

// File: verilog/motorCommand.sv
`include "motor3_cfg.svh"

module motorCommand (
    input  logic             clk,
    input  logic             arstN,
    input  logic             start,
    input  logic             freqInc,
    input  logic             freqDec,
    output logic             run,
    output logic             restart,
    output motorPkg::periodT stepPeriod
);

    localparam motorPkg::periodT PeriodInit = motorPkg::periodT'(`M3_PERIOD_INIT);
    localparam motorPkg::periodT PeriodMin  = motorPkg::periodT'(`M3_PERIOD_MIN);
    localparam motorPkg::periodT PeriodMax  = motorPkg::periodT'(`M3_PERIOD_MAX);
    localparam motorPkg::periodT PeriodStep = motorPkg::periodT'(`M3_PERIOD_STEP);

    motorPkg::periodT periodFaster;
    motorPkg::periodT periodSlower;

    // ######################################################################
    // Start edge

    // run is start delayed by one cycle, so it doubles as the edge history
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            run     <= 1'b0;
            restart <= 1'b0;
        end else begin
            run     <= start;
            restart <= start & ~run;  // Rising edge only
        end
    end

    // ######################################################################
    // Step period

    always_comb begin
        if (stepPeriod >= PeriodMin + PeriodStep) begin
            periodFaster = stepPeriod - PeriodStep;
        end else begin
            periodFaster = PeriodMin;  // Clamp
        end

        if (stepPeriod <= PeriodMax - PeriodStep) begin
            periodSlower = stepPeriod + PeriodStep;
        end else begin
            periodSlower = PeriodMax;  // Clamp
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stepPeriod <= PeriodInit;
        end else if (freqInc && !freqDec) begin
            stepPeriod <= periodFaster;  // Shorter step, higher speed
        end else if (freqDec && !freqInc) begin
            stepPeriod <= periodSlower;
        end
    end

endmodule

// File: verilog/stepSequencer.sv
`include "motor3_cfg.svh"

module stepSequencer (
    input  logic               clk,
    input  logic               arstN,
    input  logic               run,
    input  logic               restart,
    input  motorPkg::periodT   stepPeriod,
    stepIf.seq                 steps,
    output motorPkg::roundCntT rounds
);

    localparam motorPkg::stepIdxT IdleA    = 4'hF;
    localparam motorPkg::stepIdxT IdleBc   = 4'hE;
    localparam motorPkg::stepIdxT LastStep = motorPkg::stepIdxT'(`M3_STEPS - 1);

    motorPkg::periodT  cnt;
    logic              cntLast;
    logic              advance;
    logic              stepAdv;
    motorPkg::stepIdxT stepA;
    motorPkg::stepIdxT stepB;
    motorPkg::stepIdxT stepC;

    function automatic motorPkg::stepIdxT offsetStep(
        input motorPkg::stepIdxT base,
        input logic [4:0]        ofs
    );
        logic [4:0] sum;
        sum = {1'b0, base} + ofs;
        if (sum >= 5'(`M3_STEPS)) begin
            sum = sum - 5'(`M3_STEPS);  // Modulo step count
        end
        return sum[3:0];
    endfunction

    // ######################################################################
    // Period countdown

    assign cntLast = (cnt[`M3_PERIOD_W-1:1] == '0);  // Count is 1 or 0
    assign advance = run & cntLast & ~restart;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cnt <= motorPkg::periodT'(`M3_PERIOD_INIT);
        end else if (restart || advance) begin
            cnt <= stepPeriod;  // New period takes effect here only
        end else if (run) begin
            cnt <= cnt - motorPkg::periodT'(1);
        end
    end

    // ######################################################################
    // Phase A step and round count

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stepA   <= IdleA;
            stepAdv <= 1'b0;
        end else begin
            stepAdv <= restart | advance;
            if (restart) begin
                stepA <= '0;
            end else if (advance) begin
                stepA <= (stepA >= LastStep) ? '0 : stepA + 4'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rounds <= '0;
        end else if (!run) begin
            rounds <= '0;  // Stopped motor
        end else if (advance && stepA == LastStep) begin
            rounds <= rounds + motorPkg::roundCntT'(1);
        end
    end

    // B and C lead A by a fixed number of steps
    always_comb begin
        if (stepA > LastStep) begin
            stepB = IdleBc;
            stepC = IdleBc;
        end else begin
            stepB = offsetStep(stepA, 5'(`M3_OFS_B));
            stepC = offsetStep(stepA, 5'(`M3_OFS_C));
        end
    end

    assign steps.stepA   = stepA;
    assign steps.stepB   = stepB;
    assign steps.stepC   = stepC;
    assign steps.stepAdv = stepAdv;
    assign steps.run     = run;

endmodule

// File: verilog/phaseDriver.sv
`include "motor3_cfg.svh"

module phaseDriver (
    input  logic               clk,
    input  logic               arstN,
    stepIf.drv                 steps,
    output drivePkg::gatePairT gateA,
    output drivePkg::gatePairT gateB,
    output drivePkg::gatePairT gateC
);

    localparam motorPkg::stepIdxT HalfStep = motorPkg::stepIdxT'(`M3_STEPS / 2);
    localparam motorPkg::stepIdxT LastStep = motorPkg::stepIdxT'(`M3_STEPS - 1);

    logic runQ;
    logic load;

    // One dead step before each half of the round
    function automatic drivePkg::bridgeStateT bridgeOf(
        input motorPkg::stepIdxT idx,
        input logic              on
    );
        drivePkg::bridgeStateT state;
        state = drivePkg::bridgeOff;
        if (on && idx < HalfStep - 4'd1) begin
            state = drivePkg::bridgeHigh;
        end else if (on && idx >= HalfStep && idx < LastStep) begin
            state = drivePkg::bridgeLow;
        end
        return state;
    endfunction

    function automatic drivePkg::gatePairT gatesOf(input drivePkg::bridgeStateT state);
        case (state)
            drivePkg::bridgeHigh: return 2'b10;
            drivePkg::bridgeLow:  return 2'b01;
            default:              return 2'b00;  // Floating
        endcase
    endfunction

    // Steps only move with stepAdv, so gates reload on that or a run change
    assign load = steps.stepAdv | (steps.run ^ runQ);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            runQ  <= 1'b0;
            gateA <= '0;
            gateB <= '0;
            gateC <= '0;
        end else begin
            runQ <= steps.run;
            if (load) begin
                gateA <= gatesOf(bridgeOf(steps.stepA, steps.run));
                gateB <= gatesOf(bridgeOf(steps.stepB, steps.run));
                gateC <= gatesOf(bridgeOf(steps.stepC, steps.run));
            end
        end
    end

endmodule

// File: verilog/motor3Top.sv
module motor3Top (
    input  logic               clk,
    input  logic               arstN,
    input  logic               start,
    input  logic               freqInc,
    input  logic               freqDec,
    output drivePkg::gatePairT gateA,
    output drivePkg::gatePairT gateB,
    output drivePkg::gatePairT gateC,
    output motorPkg::stepIdxT  stepA,
    output motorPkg::roundCntT rounds
);

    logic             run;
    logic             restart;
    motorPkg::periodT stepPeriod;

    stepIf stepBus ();

    motorCommand cmd0 (
        .clk        (clk),
        .arstN      (arstN),
        .start      (start),
        .freqInc    (freqInc),
        .freqDec    (freqDec),
        .run        (run),
        .restart    (restart),
        .stepPeriod (stepPeriod)
    );

    stepSequencer seq0 (
        .clk        (clk),
        .arstN      (arstN),
        .run        (run),
        .restart    (restart),
        .stepPeriod (stepPeriod),
        .steps      (stepBus.seq),
        .rounds     (rounds)
    );

    phaseDriver drv0 (
        .clk   (clk),
        .arstN (arstN),
        .steps (stepBus.drv),
        .gateA (gateA),
        .gateB (gateB),
        .gateC (gateC)
    );

    assign stepA = stepBus.stepA;  // Status tap

endmodule

// File: bench/motor3Tb.sv
`include "motor3_cfg.svh"

module motor3Tb;

    localparam int ClkPeriod   = 10;
    localparam int ResetCycles = 10;
    localparam int NumRuns     = 6;
    localparam int RunMin      = 500;  // Longer than one round at the slowest period
    localparam int RunSpan     = 512;
    localparam int IdleMin     = 20;
    localparam int IdleSpan    = 16;
    localparam int MaxTestCycles =
        ResetCycles + 10 + NumRuns * (RunMin + RunSpan + IdleMin + IdleSpan + 2);

    logic               clk;
    logic               arstN;
    logic               start;
    logic               freqInc;
    logic               freqDec;
    drivePkg::gatePairT gateA;
    drivePkg::gatePairT gateB;
    drivePkg::gatePairT gateC;
    motorPkg::stepIdxT  stepA;
    motorPkg::roundCntT rounds;

    integer             seed;

    // Reference model state
    logic               runM;
    logic               restartDue;
    int                 periodM;
    int                 stepLeft;  // Cycles left in the current step
    motorPkg::stepIdxT  expStep;
    motorPkg::roundCntT expRounds;
    drivePkg::gatePairT expGateA;
    drivePkg::gatePairT expGateB;
    drivePkg::gatePairT expGateC;

    motor3Top dut0 (
        .clk     (clk),
        .arstN   (arstN),
        .start   (start),
        .freqInc (freqInc),
        .freqDec (freqDec),
        .gateA   (gateA),
        .gateB   (gateB),
        .gateC   (gateC),
        .stepA   (stepA),
        .rounds  (rounds)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic checkValue(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        assert (actual === expected) else begin
            $display("error %s expected %h actual %h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    // Half-bridge rule with a dead step at 5 and 11
    function automatic drivePkg::gatePairT bridgeGates(input int idx, input logic on);
        drivePkg::gatePairT gates;
        gates = 2'b00;
        if (on && idx >= 0 && idx <= 4) begin
            gates = 2'b10;
        end else if (on && idx >= 6 && idx <= 10) begin
            gates = 2'b01;
        end
        return gates;
    endfunction

    function automatic int leadIndex(input int a, input int ofs);
        int idx;
        idx = (a < `M3_STEPS) ? (a + ofs) % `M3_STEPS : 14;  // 14 is idle for B and C
        return idx;
    endfunction

    // ######################################################################
    // Reference model

    always @(posedge clk or negedge arstN) begin
        int a;
        if (!arstN) begin
            runM       = 1'b0;
            restartDue = 1'b0;
            periodM    = `M3_PERIOD_INIT;
            stepLeft   = 0;
            expStep    = 4'hF;
            expRounds  = '0;
            expGateA   = 2'b00;
            expGateB   = 2'b00;
            expGateC   = 2'b00;
        end else begin
            a = int'(expStep);
            expGateA = bridgeGates(a, runM);  // Gates follow last cycle's steps
            expGateB = bridgeGates(leadIndex(a, `M3_OFS_B), runM);
            expGateC = bridgeGates(leadIndex(a, `M3_OFS_C), runM);
            if (restartDue) begin
                expStep  = '0;
                stepLeft = periodM;
            end else if (runM) begin
                if (stepLeft == 1) begin
                    expStep  = motorPkg::stepIdxT'((a + 1) % `M3_STEPS);
                    stepLeft = periodM;  // Period as it stood before this edge
                    if ((a + 1) % `M3_STEPS == 0) begin
                        expRounds = expRounds + motorPkg::roundCntT'(1);
                    end
                end else begin
                    stepLeft = stepLeft - 1;
                end
            end
            if (!runM) begin
                expRounds = '0;
            end
            restartDue = start && !runM;
            runM       = start;
            if (freqInc && !freqDec) begin
                periodM = (periodM - `M3_PERIOD_STEP < `M3_PERIOD_MIN) ?
                          `M3_PERIOD_MIN : periodM - `M3_PERIOD_STEP;
            end else if (freqDec && !freqInc) begin
                periodM = (periodM + `M3_PERIOD_STEP > `M3_PERIOD_MAX) ?
                          `M3_PERIOD_MAX : periodM + `M3_PERIOD_STEP;
            end
        end
    end

    // ######################################################################
    // Checks

    noShootThrough: assert property (@(posedge clk) disable iff (!arstN)
        !(&gateA) && !(&gateB) && !(&gateC))
        else abortRun("high and low switch of one phase were on together");

    always @(negedge clk) begin
        if (arstN) begin
            checkValue("stepA", 32'(expStep), 32'(stepA));
            checkValue("rounds", 32'(expRounds), 32'(rounds));
            checkValue("gateA", 32'(expGateA), 32'(gateA));
            checkValue("gateB", 32'(expGateB), 32'(gateB));
            checkValue("gateC", 32'(expGateC), 32'(gateC));
        end
    end

    initial begin
        #((MaxTestCycles + 100) * ClkPeriod);
        abortRun("watchdog expired before the test sequence finished");
    end

    // ######################################################################
    // Stimulus

    initial begin
        int          runCycles;
        int          idleCycles;
        int          burstLeft;
        logic [1:0]  burstKind;  // 0 faster, 1 and 3 slower, 2 both at once
        logic [31:0] r;
        seed    = 53;
        clk     = 1'b0;
        arstN   = 1'b0;
        start   = 1'b0;
        freqInc = 1'b0;
        freqDec = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #1;
        arstN = 1'b1;
        repeat (4) nextCycle();  // Reset state with start low
        for (int n = 0; n < NumRuns; n++) begin
            r = $random(seed);
            runCycles = RunMin + int'(r[8:0]);
            idleCycles = IdleMin + int'(r[12:9]);
            burstLeft = 0;
            burstKind = 2'd0;
            for (int c = 0; c < runCycles; c++) begin
                r = $random(seed);
                if (burstLeft == 0 && r[5:0] == 6'd0) begin
                    burstLeft = 1 + int'(r[9:6]);  // Up to 16 pulses so the period can pass a limit
                    burstKind = r[11:10];
                end
                start   = 1'b1;
                freqInc = (burstLeft > 0) && (burstKind == 2'd0 || burstKind == 2'd2);
                freqDec = (burstLeft > 0) && (burstKind != 2'd0);
                if (burstLeft > 0) begin
                    burstLeft = burstLeft - 1;
                end
                nextCycle();
            end
            start   = 1'b0;
            freqInc = 1'b0;
            freqDec = 1'b0;
            repeat (idleCycles) nextCycle();
        end
        repeat (4) nextCycle();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: motor3.f
+incdir+verilog
verilog/motorPkg.sv
verilog/drivePkg.sv
verilog/stepIf.sv
verilog/motorCommand.sv
verilog/stepSequencer.sv
verilog/phaseDriver.sv
verilog/motor3Top.sv
bench/motor3Tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f motor3.f --top-module motor3Tb -o motor3Sim &&
./obj_dir/motor3Sim || exit 1
